//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
    -f rv_core.f -o rv_core_sim > build.log 2>&1 \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -q "^SIMULATION PASSED$" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

//--- rv_core.f
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_control.sv
src/rv_datapath.sv
src/rv_apb_master.sv
src/rv_core.sv
test/rv_checker.sv
test/rv_core_props.sv
test/rv_core_tb.sv

//--- src/rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  wire logic [xlen-1:0] a,
    input  wire logic [xlen-1:0] b,
    input  wire alu_op_e         op,
    input  wire logic [2:0]      branch_f3,
    output logic      [xlen-1:0] result,
    output logic                 cond
);

    logic [4:0] shamt;
    logic       lt_s, lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(xlen-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(xlen-1){1'b0}}, lt_u};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // the branch condition is encoded as in the funct3 field of the branch.
    always_comb begin
        case (branch_f3)
            3'b000:  cond = (a == b);
            3'b001:  cond = (a != b);
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/rv_apb_master.sv
`timescale 1ns/100ps
`default_nettype none

module rv_apb_master import rv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire mem_req_t mem_req,
    output mem_rsp_t      mem_rsp,
    output apb_req_t      apb_req,
    input  wire apb_rsp_t apb_rsp
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

    apb_state_e      state;
    logic            pwrite_q;
    logic [xlen-1:0] paddr_q, pwdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= (mem_req.read || mem_req.write) ? SETUP : IDLE;
                SETUP:   state <= ACCESS;
                default: state <= apb_rsp.pready ? IDLE : ACCESS;
            endcase
        end
    end

    // the request is captured once and held for the whole transfer.
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            pwrite_q <= mem_req.write;
            paddr_q  <= mem_req.addr;
            pwdata_q <= mem_req.wdata;
        end
    end

    assign apb_req.psel    = (state != IDLE);
    assign apb_req.penable = (state == ACCESS);
    assign apb_req.pwrite  = pwrite_q;
    assign apb_req.paddr   = paddr_q;
    assign apb_req.pwdata  = pwdata_q;

    assign mem_rsp.complete = (state == ACCESS) && apb_rsp.pready;
    assign mem_rsp.rdata    = apb_rsp.prdata;

endmodule

`default_nettype wire

//--- src/rv_control.sv
`timescale 1ns/100ps
`default_nettype none

module rv_control import rv_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire opcode_e opcode,
    input  wire logic    mem_complete,
    output ctrl_t        ctrl
);

    mcp_state_e mcp_reg;
    mcp_state_e mcp_next;
    mcp_state_e mcp_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcp_reg <= MCP_FETCH;
        end else begin
            mcp_reg <= mcp_next;
        end
    end

    // in DISPATCH the address is the first micro-state of the opcode.
    always_comb begin
        mcp_addr = mcp_reg;
        if (mcp_reg == MCP_DISPATCH) begin
            case (opcode)
                OPC_LUI:    mcp_addr = MCP_LUI;
                OPC_AUIPC:  mcp_addr = MCP_AUIPC;
                OPC_JAL:    mcp_addr = MCP_JAL;
                OPC_JALR:   mcp_addr = MCP_JALR;
                OPC_BRANCH: mcp_addr = MCP_BRANCH;
                OPC_OPIMM:  mcp_addr = MCP_OPIMM;
                OPC_OP:     mcp_addr = MCP_OP;
                OPC_LOAD:   mcp_addr = MCP_LOAD;
                OPC_STORE:  mcp_addr = MCP_STORE;
                default:    mcp_addr = MCP_NOP;
            endcase
        end
    end

    // ========================================
    // microcode
    // ========================================

    always_comb begin
        ctrl.write_ir  = 1'b0;
        ctrl.write_pc  = 1'b0;
        ctrl.write_rd  = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.alu_funct = 1'b0;
        ctrl.alu1_sel  = ALU1_REG;
        ctrl.alu2_sel  = ALU2_REG;
        ctrl.rd_sel    = RD_ALU;
        ctrl.pc_sel    = PC_PLUS4;
        mcp_next       = MCP_FETCH;
        if (mcp_reg == MCP_DISPATCH) begin
            // the dispatch cycle itself does no work.
            mcp_next = mcp_addr;
        end else begin
            case (mcp_addr)
                MCP_FETCH: begin
                    ctrl.mem_read = 1'b1;
                    ctrl.write_ir = mem_complete;
                    mcp_next      = mem_complete ? MCP_DISPATCH : MCP_FETCH;
                end
                MCP_LUI, MCP_AUIPC: begin
                    ctrl.alu1_sel = (mcp_addr == MCP_LUI) ? ALU1_ZERO : ALU1_PC;
                    ctrl.alu2_sel = ALU2_IMM;
                    ctrl.write_rd = 1'b1;
                    ctrl.write_pc = 1'b1;
                end
                MCP_JAL, MCP_JALR: begin
                    // the ALU forms rs1 plus offset; JAL uses its own target adder.
                    ctrl.alu2_sel = ALU2_IMM;
                    ctrl.rd_sel   = RD_PC4;
                    ctrl.pc_sel   = (mcp_addr == MCP_JAL) ? PC_JUMP : PC_REG;
                    ctrl.write_rd = 1'b1;
                    ctrl.write_pc = 1'b1;
                end
                MCP_BRANCH: begin
                    ctrl.pc_sel   = PC_BRANCH;
                    ctrl.write_pc = 1'b1;
                end
                MCP_OPIMM, MCP_OP: begin
                    ctrl.alu2_sel  = (mcp_addr == MCP_OPIMM) ? ALU2_IMM : ALU2_REG;
                    ctrl.alu_funct = 1'b1;
                    ctrl.write_rd  = 1'b1;
                    ctrl.write_pc  = 1'b1;
                end
                MCP_LOAD: begin
                    ctrl.alu2_sel = ALU2_IMM;
                    ctrl.rd_sel   = RD_MEM;
                    ctrl.mem_read = 1'b1;
                    mcp_next      = mem_complete ? MCP_LOAD_1 : MCP_LOAD;
                end
                MCP_LOAD_1: begin
                    ctrl.rd_sel   = RD_MEM;
                    ctrl.write_rd = 1'b1;
                    ctrl.write_pc = 1'b1;
                end
                MCP_STORE: begin
                    ctrl.alu2_sel  = ALU2_IMM;
                    ctrl.mem_write = 1'b1;
                    ctrl.write_pc  = mem_complete;
                    mcp_next       = mem_complete ? MCP_FETCH : MCP_STORE;
                end
                default: begin
                    // unknown opcodes only step the PC.
                    ctrl.write_pc = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    output apb_req_t      apb_req,
    input  wire apb_rsp_t apb_rsp
);

    ctrl_t    ctrl;
    opcode_e  opcode;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    rv_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .opcode       (opcode),
        .mem_complete (mem_rsp.complete),
        .ctrl         (ctrl)
    );

    rv_datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .mem_rsp (mem_rsp),
        .opcode  (opcode),
        .mem_req (mem_req)
    );

    rv_apb_master u_apb_master (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

`default_nettype wire

//--- src/rv_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module rv_datapath import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire ctrl_t    ctrl,
    input  wire mem_rsp_t mem_rsp,
    output opcode_e       opcode,
    output mem_req_t      mem_req
);

    logic [xlen-1:0] pc_q, ir_q, load_q;
    logic [xlen-1:0] rs1_data, rs2_data, rd_data;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    logic [xlen-1:0] alu_a, alu_b, alu_result;
    logic [xlen-1:0] pc_plus4, target, pc_next;
    logic [2:0]      funct3;
    logic            cond;
    alu_op_e         alu_op;

    assign opcode = opcode_e'(ir_q[6:0]);
    assign funct3 = ir_q[14:12];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else if (ctrl.write_pc) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.write_ir) begin
            ir_q <= mem_rsp.rdata;
        end
        if (mem_rsp.complete) begin
            load_q <= mem_rsp.rdata;
        end
    end

    // ========================================
    // immediates and operands
    // ========================================

    assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
    assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
    assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
    assign imm_u = {ir_q[31:12], 12'b0};
    assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = imm_u;
            OPC_STORE:          imm = imm_s;
            default:            imm = imm_i;
        endcase
        case (ctrl.alu1_sel)
            ALU1_PC:   alu_a = pc_q;
            ALU1_ZERO: alu_a = '0;
            default:   alu_a = rs1_data;
        endcase
        alu_b = (ctrl.alu2_sel == ALU2_IMM) ? imm : rs2_data;
    end

    // bit 5 of the opcode separates OP, where bit 30 selects sub, from OP-IMM.
    always_comb begin
        alu_op = ALU_ADD;
        if (ctrl.alu_funct) begin
            case (funct3)
                3'b000:  alu_op = (ir_q[5] && ir_q[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ir_q[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // ========================================
    // next PC and writeback
    // ========================================

    assign pc_plus4 = pc_q + 32'd4;
    assign target   = pc_q + ((opcode == OPC_BRANCH) ? imm_b : imm_j);

    always_comb begin
        case (ctrl.pc_sel)
            PC_JUMP:   pc_next = target;
            PC_REG:    pc_next = {alu_result[xlen-1:1], 1'b0};
            PC_BRANCH: pc_next = cond ? target : pc_plus4;
            default:   pc_next = pc_plus4;
        endcase
        case (ctrl.rd_sel)
            RD_MEM:  rd_data = load_q;
            RD_PC4:  rd_data = pc_plus4;
            default: rd_data = alu_result;
        endcase
    end

    // data accesses address through the ALU, fetches use the PC.
    assign mem_req.read  = ctrl.mem_read;
    assign mem_req.write = ctrl.mem_write;
    assign mem_req.addr  = (ctrl.mem_write || ctrl.rd_sel == RD_MEM) ? alu_result : pc_q;
    assign mem_req.wdata = rs2_data;

    rv_regfile u_regfile (
        .clk      (clk),
        .rs1_addr (ir_q[19:15]),
        .rs2_addr (ir_q[24:20]),
        .rd_addr  (ir_q[11:7]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (ctrl.write_rd),
        .rd_data  (rd_data)
    );

    rv_alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (alu_op),
        .branch_f3 (funct3),
        .result    (alu_result),
        .cond      (cond)
    );

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // ========================================
    // instruction and micro-state encodings
    // ========================================

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [4:0] {
        MCP_FETCH    = 5'd0,
        MCP_DISPATCH = 5'd1,
        MCP_LUI      = 5'd2,
        MCP_AUIPC    = 5'd3,
        MCP_JAL      = 5'd4,
        MCP_JALR     = 5'd5,
        MCP_BRANCH   = 5'd6,
        MCP_OPIMM    = 5'd7,
        MCP_OP       = 5'd8,
        MCP_LOAD     = 5'd9,
        MCP_LOAD_1   = 5'd10,
        MCP_STORE    = 5'd11,
        MCP_NOP      = 5'd12
    } mcp_state_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {ALU1_REG, ALU1_PC, ALU1_ZERO} alu1_sel_e;
    typedef enum logic [1:0] {ALU2_REG, ALU2_IMM} alu2_sel_e;
    typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_PC4} rd_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_JUMP, PC_REG, PC_BRANCH} pc_sel_e;

    // ========================================
    // control word and bus structs
    // ========================================

    typedef struct packed {
        logic      write_ir;
        logic      write_pc;
        logic      write_rd;
        logic      mem_read;
        logic      mem_write;
        // take the operation from funct3 and funct7 instead of a plain add.
        logic      alu_funct;
        alu1_sel_e alu1_sel;
        alu2_sel_e alu2_sel;
        rd_sel_e   rd_sel;
        pc_sel_e   pc_sel;
    } ctrl_t;

    typedef struct packed {
        logic            read;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            complete;
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [xlen-1:0] paddr;
        logic [xlen-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire logic            clk,
    input  wire logic [4:0]      rs1_addr,
    input  wire logic [4:0]      rs2_addr,
    input  wire logic [4:0]      rd_addr,
    output logic      [xlen-1:0] rs1_data,
    output logic      [xlen-1:0] rs2_data,
    input  wire logic            we,
    input  wire logic [xlen-1:0] rd_data
);

    // x0 has no storage.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- test/rv_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_checker import rv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req,
    input  wire apb_rsp_t apb_rsp,
    output logic          done,
    output int            errors
);

    typedef struct packed {
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } xfer_t;

    logic [xlen-1:0] model_mem [0:1023];
    logic [xlen-1:0] regs [0:31];
    logic [xlen-1:0] pc;
    logic            at_loop;
    xfer_t           expect_q [$];

    task load_word(input int idx, input logic [xlen-1:0] w);
        model_mem[idx[9:0]] = w;
    endtask

    function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // executes one instruction and queues the transfers it makes.
    task step_model();
        logic [xlen-1:0] ins, imm_i, imm_s, imm_b, imm_j, addr, res, npc;
        logic [4:0]      rd, rs1, rs2;
        logic [2:0]      f3;
        logic            wr_rd;
        ins   = model_mem[pc[11:2]];
        expect_q.push_back({1'b0, pc, 32'd0});
        rd    = ins[11:7];
        rs1   = ins[19:15];
        rs2   = ins[24:20];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        npc   = pc + 32'd4;
        res   = pc + 32'd4;
        wr_rd = 1'b1;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010111: res = pc + {ins[31:12], 12'b0};
            7'b1101111: begin
                npc     = pc + imm_j;
                at_loop = (imm_j == 32'd0);
            end
            7'b1100111: npc = (regs[rs1] + imm_i) & ~32'd1;
            7'b1100011: begin
                wr_rd = 1'b0;
                if (branch_taken(f3, regs[rs1], regs[rs2])) begin
                    npc = pc + imm_b;
                end
            end
            7'b0000011: begin
                addr = regs[rs1] + imm_i;
                expect_q.push_back({1'b0, addr, 32'd0});
                res = model_mem[addr[11:2]];
            end
            7'b0100011: begin
                addr  = regs[rs1] + imm_s;
                wr_rd = 1'b0;
                expect_q.push_back({1'b1, addr, regs[rs2]});
                model_mem[addr[11:2]] = regs[rs2];
            end
            7'b0010011: res = alu_model(f3, f3 == 3'd5 && ins[30], regs[rs1], imm_i);
            7'b0110011: res = alu_model(f3, ins[30], regs[rs1], regs[rs2]);
            default:    wr_rd = 1'b0;
        endcase
        if (wr_rd && rd != 5'd0) begin
            regs[rd] = res;
        end
        pc = npc;
    endtask

    initial begin
        xfer_t exp_x;
        int    count;
        done    = 1'b0;
        errors  = 0;
        count   = 0;
        pc      = '0;
        at_loop = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        forever begin
            @(posedge clk);
            if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
                if (expect_q.size() == 0) begin
                    step_model();
                end
                exp_x = expect_q.pop_front();
                count++;
                if (exp_x.write !== apb_req.pwrite || exp_x.addr !== apb_req.paddr ||
                    (exp_x.write && exp_x.data !== apb_req.pwdata)) begin
                    errors++;
                    $display("[ERROR] %0t: transfer %0d expected %s %h data %h, got %s %h data %h",
                             $time, count, exp_x.write ? "write" : "read", exp_x.addr,
                             exp_x.data, apb_req.pwrite ? "write" : "read", apb_req.paddr,
                             apb_req.pwdata);
                end
                if (at_loop && expect_q.size() == 0) begin
                    done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/rv_core_props.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_props import rv_pkg::*; (
    input wire logic     clk,
    input wire logic     rst_n,
    input wire apb_req_t apb_req,
    input wire apb_rsp_t apb_rsp
);

    penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel)
        else $error("penable high without psel");

    // until the completing cycle the transfer must not change.
    hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=>
            apb_req.psel && $stable(apb_req.paddr) && $stable(apb_req.pwrite) &&
            $stable(apb_req.pwdata))
        else $error("APB request changed before completion");

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !apb_req.psel)
        else $error("psel high right after reset");

    word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel |-> apb_req.paddr[1:0] == 2'b00)
        else $error("paddr not word aligned");

endmodule

bind rv_apb_master rv_core_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
);

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int period     = 10;
    localparam int body_words = 90;

    logic            clk;
    logic            rst_n;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    logic            done;
    int              errors;
    logic            prog_ready;
    int              prog_len;
    int              wr_ptr;
    logic [31:0]     lfsr;
    logic [xlen-1:0] mem [0:1023];

    rv_core #(.reset_pc(32'h0)) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    rv_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .done    (done),
        .errors  (errors)
    );

    // the galois LFSR steps once for each bit handed out.
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // ========================================
    // instruction encoding
    // ========================================

    function logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task put_word(input logic [31:0] w);
        mem[wr_ptr[9:0]] = w;
        wr_ptr++;
    endtask

    // emits one straight-line instruction out of LUI, AUIPC, OP-IMM, OP, LW and SW.
    task gen_plain();
        logic [2:0]  kind;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        kind = 3'(take_bits(3));
        rd   = 5'(take_bits(5));
        rs1  = 5'(take_bits(5));
        rs2  = 5'(take_bits(5));
        f3   = 3'(take_bits(3));
        imm  = 12'(take_bits(12));
        alt  = 1'(take_bits(1));
        case (kind)
            3'd0: put_word({20'(take_bits(20)), rd, 7'b0110111});
            3'd1: put_word({20'(take_bits(20)), rd, 7'b0010111});
            3'd2, 3'd3: begin
                if (f3 == 3'd1) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};
                end
                put_word(enc_i(imm, rs1, f3, rd, 7'b0010011));
            end
            3'd4, 3'd5: begin
                alt = alt && (f3 == 3'd0 || f3 == 3'd5);
                put_word({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
            end
            3'd6: put_word(enc_i({4'b0100, imm[5:0], 2'b00}, 5'd0, 3'b010, rd, 7'b0000011));
            default: put_word(enc_s({4'b0100, imm[5:0], 2'b00}, rs2));
        endcase
    endtask

    // a forward branch or jump over 1 to 4 straight-line words.
    task gen_control();
        logic [1:0] kind;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [2:0] skip;
        int         off;
        kind = 2'(take_bits(2));
        rd   = 5'(take_bits(5));
        rs1  = 5'(take_bits(5));
        rs2  = 5'(take_bits(5));
        f3   = 3'(take_bits(3));
        skip = 3'(take_bits(2)) + 3'd1;
        off  = 4 * (int'(skip) + 1);
        case (kind)
            2'd0, 2'd1: begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 ^ 3'b110;
                end
                put_word(enc_b(13'(off), rs2, rs1, f3));
            end
            2'd2: put_word(enc_j(21'(off), rd));
            default: begin
                if (rs1 == 5'd0) begin
                    rs1 = 5'd7;
                end
                // AUIPC gives JALR a base; bit 0 of the offset must be dropped.
                put_word({20'd0, rs1, 7'b0010111});
                put_word(enc_i(12'(off + 4) | {11'b0, 1'(take_bits(1))}, rs1, 3'b000, rd,
                               7'b1100111));
            end
        endcase
        repeat (skip) gen_plain();
    endtask

    // ========================================
    // clock, APB completer and watchdog
    // ========================================

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin : completer
        int waits;
        waits          = 0;
        apb_rsp.pready = 1'b0;
        apb_rsp.prdata = '0;
        forever begin
            @(negedge clk);
            if (apb_req.psel && !apb_req.penable) begin
                waits          = int'(take_bits(2));
                apb_rsp.pready = 1'b0;
            end else if (apb_req.psel && apb_req.penable) begin
                if (waits == 0) begin
                    apb_rsp.pready = 1'b1;
                    if (apb_req.pwrite) begin
                        mem[apb_req.paddr[11:2]] = apb_req.pwdata;
                    end else begin
                        apb_rsp.prdata = mem[apb_req.paddr[11:2]];
                    end
                end else begin
                    waits--;
                end
            end else begin
                apb_rsp.pready = 1'b0;
            end
        end
    end

    initial begin
        wait (prog_ready);
        repeat ((prog_len + 8) * 12) @(posedge clk);
        $display("timeout: the core stopped making progress through the program");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        prog_ready = 1'b0;
        lfsr       = 32'hfe71_eea5;
        wr_ptr     = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i[9:0]] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
        end
        for (int i = 256; i < 320; i++) begin
            mem[i[9:0]] = take_bits(32);
        end
        for (int r = 1; r < 32; r++) begin
            put_word({20'(take_bits(20)), 5'(r), 7'b0110111});
        end
        while (wr_ptr < 31 + body_words) begin
            if (take_bits(2) == 32'd0) begin
                gen_control();
            end else begin
                gen_plain();
            end
        end
        for (int r = 1; r < 32; r++) begin
            put_word(enc_s({4'b0100, 6'(r - 1), 2'b00}, 5'(r)));
        end
        put_word(enc_j(21'd0, 5'd0));
        prog_len = wr_ptr;
        for (int i = 0; i < 1024; i++) begin
            u_checker.load_word(i, mem[i[9:0]]);
        end
        prog_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        wait (done);
        @(negedge clk);
        $display("closing: %0d transfer mismatches over %0d program words", errors, prog_len);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
